// ==== build.f ====
+incdir+verilog
verilog/mbist_cfg_pkg.sv
verilog/mbist_reg_decode.sv
verilog/mbist_ctrl_regs.sv
verilog/mbist_serial_shift.sv
verilog/mbist_read_result.sv
verilog/mbist_cfg_top.sv
dv/mbist_scan_model.sv
dv/tb_mbist_cfg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the MBIST config testbench with Verilator and run it.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_mbist_cfg

verilator --binary --timing --assert -f build.f --top-module "$TOP" -Mdir "$OBJ" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== dv/tb_mbist_cfg.sv ====
// --------------------
// Testbench for the MBIST config block: random bus
// traffic, register and scan chain model, checks
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module tb_mbist_cfg;

    localparam int timeout_cyc = 200;

    logic                     mclk;
    logic                     reset_n;
    logic                     reg_cs;
    logic                     reg_wr;
    logic [`MBIST_ADDR_W-1:0] reg_addr;
    logic [`MBIST_DATA_W-1:0] reg_wdata;
    logic [`MBIST_BE_W-1:0]   reg_be;
    logic [`MBIST_DATA_W-1:0] reg_rdata;
    logic                     reg_ack;
    logic [7:0]               bist_en;
    logic [7:0]               bist_run;
    logic [7:0]               bist_load;
    logic [7:0]               bist_sdi;
    logic [7:0]               bist_shift;
    logic [7:0]               bist_sdo;
    logic [7:0]               bist_done;
    logic [7:0]               bist_error;
    logic [7:0]               bist_correct;
    mbist_cfg_pkg::err_cnt_t  bist_error_cnt;

    // Register and chain model
    logic [31:0]              scratch0_m;
    logic [31:0]              scratch1_m;
    logic [31:0]              ctrl_m;
    logic [31:0]              prev_m;
    logic [7:0]               sel_m;
    logic [31:0]              chain_m [8];
    int unsigned              shift_exp [8];
    int                       err_cnt;
    int                       chk_cnt;

    mbist_cfg_top u_dut (.*);

    mbist_scan_model u_scan (.*);

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One bus transfer, cs held until ack
    task automatic bus_xfer(input logic wr, input logic [3:0] idx, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
        int wait_cyc;
        wait_cyc = 0;
        @(posedge mclk);
        reg_cs    <= 1'b1;
        reg_wr    <= wr;
        reg_addr  <= {2'b00, idx, 2'b00};
        reg_wdata <= wdata;
        reg_be    <= be;
        @(negedge mclk);
        while (!reg_ack && wait_cyc < timeout_cyc) begin
            wait_cyc++;
            @(negedge mclk);
        end
        if (!reg_ack) begin
            $display("Timeout: no reg_ack after %0d cycles at index %0d", timeout_cyc, idx);
            $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            rdata = reg_rdata;
            @(posedge mclk);
            reg_cs <= 1'b0;
            reg_wr <= 1'b0;
        end
    endtask

    // Only enabled bytes take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                                input logic [31:0] wd, input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (cur & ~mask) | (wd & mask);
    endfunction

    // Four engines per word, byte = {cnt, 0, correct, error, done}
    function automatic logic [31:0] status_word(input int base);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = {bist_error_cnt[base+k], 1'b0, bist_correct[base+k],
                           bist_error[base+k], bist_done[base+k]};
        end
        return w;
    endfunction

    // Expected plain read per index
    function automatic logic [31:0] expect_read(input logic [3:0] idx);
        case (idx)
            `REG_SCRATCH0:  return scratch0_m;
            `REG_SCRATCH1:  return scratch1_m;
            `REG_SER_SEL:   return {24'h0, sel_m};
            `REG_BIST_CTRL: return ctrl_m;
            `REG_STATUS_LO: return status_word(0);
            `REG_STATUS_HI: return status_word(4);
            `REG_SER_PREV:  return prev_m;
            default:        return 32'h0;
        endcase
    endfunction

    // Lane i: bit 4i enable, 4i+1 run, 4i+2 load
    task automatic check_levels();
        logic [7:0] en_e;
        logic [7:0] run_e;
        logic [7:0] load_e;
        @(negedge mclk);
        for (int i = 0; i < 8; i++) begin
            en_e[i]   = ctrl_m[4*i];
            run_e[i]  = ctrl_m[4*i+1];
            load_e[i] = ctrl_m[4*i+2];
        end
        check_word("bist_en", 32'(bist_en), 32'(en_e));
        check_word("bist_run", 32'(bist_run), 32'(run_e));
        check_word("bist_load", 32'(bist_load), 32'(load_e));
    endtask

    // Chain contents and shift counts against the model
    task automatic check_chains();
        for (int i = 0; i < 8; i++) begin
            check_word($sformatf("chain %0d", i), u_scan.chain[i], chain_m[i]);
            check_word($sformatf("shift count %0d", i), u_scan.shift_cnt[i], shift_exp[i]);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] old;
        logic [3:0]  be;
        logic [3:0]  idx;
        logic [2:0]  eng;
        logic [7:0]  sel;
        void'($urandom(93));
        err_cnt        = 0;
        chk_cnt        = 0;
        reset_n        = 1'b0;
        reg_cs         = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        reg_be         = '0;
        bist_done      = '0;
        bist_error     = '0;
        bist_correct   = '0;
        bist_error_cnt = '0;
        repeat (8) @(posedge mclk);
        reset_n <= 1'b1;
        @(negedge mclk);

        scratch0_m = `RST_SCRATCH0;
        scratch1_m = `RST_SCRATCH1;
        ctrl_m     = '0;
        prev_m     = '0;
        sel_m      = '0;
        for (int i = 0; i < 8; i++) begin
            chain_m[i]   = u_scan.chain[i];
            shift_exp[i] = 0;
        end

        // --------------------
        // Reset values
        // --------------------
        check_word("engine levels after reset", {bist_en, bist_run, bist_load, bist_shift}, '0);
        check_word("bist_sdi after reset", 32'(bist_sdi), '0);
        check_word("reg_ack after reset", 32'(reg_ack), '0);
        // SER_RD skipped, a read there would shift
        for (int r = 0; r <= 8; r++) begin
            if (r != `REG_SER_RD) begin
                bus_xfer(1'b0, 4'(r), '0, '0, rd);
                check_word($sformatf("index %0d after reset", r), rd, expect_read(4'(r)));
            end
        end

        // --------------------
        // Byte-enable writes, levels, unused reads
        // --------------------
        for (int n = 0; n < 24; n++) begin
            idx = 4'($urandom_range(0, 3));
            wd  = $urandom;
            be  = 4'($urandom);
            bus_xfer(1'b1, idx, wd, be, rd);
            case (idx)
                `REG_SCRATCH0: scratch0_m = merge_bytes(scratch0_m, wd, be);
                `REG_SCRATCH1: scratch1_m = merge_bytes(scratch1_m, wd, be);
                `REG_SER_SEL: begin
                    if (be[0]) begin
                        sel_m = wd[7:0];
                    end
                end
                default:       ctrl_m = merge_bytes(ctrl_m, wd, be);
            endcase
            bus_xfer(1'b0, idx, '0, '0, rd);
            check_word($sformatf("index %0d readback", idx), rd, expect_read(idx));
            check_levels();
            idx = 4'($urandom_range(9, 15));
            bus_xfer(1'b0, idx, '0, '0, rd);
            check_word($sformatf("unused index %0d", idx), rd, 32'h0);
        end

        // Status words from random engine inputs
        for (int n = 0; n < 8; n++) begin
            @(posedge mclk);
            bist_done      <= 8'($urandom);
            bist_error     <= 8'($urandom);
            bist_correct   <= 8'($urandom);
            bist_error_cnt <= $urandom;
            bus_xfer(1'b0, `REG_STATUS_LO, '0, '0, rd);
            check_word("status low", rd, expect_read(`REG_STATUS_LO));
            bus_xfer(1'b0, `REG_STATUS_HI, '0, '0, rd);
            check_word("status high", rd, expect_read(`REG_STATUS_HI));
        end

        // --------------------
        // Serial port, in-range select
        // --------------------
        // A 32-bit shift swaps shifter and chain
        for (int n = 0; n < 6; n++) begin
            eng   = 3'($urandom_range(0, 7));
            sel_m = {5'b0, eng};
            bus_xfer(1'b1, `REG_SER_SEL, {24'($urandom), sel_m}, 4'hF, rd);
            wd = $urandom;
            bus_xfer(1'b1, `REG_SER_WR, wd, 4'hF, rd);
            check_word("serial write data", rd, chain_m[eng]);
            prev_m       = chain_m[eng];
            chain_m[eng] = wd;
            shift_exp[eng] += 32;
            bus_xfer(1'b0, `REG_SER_RD, '0, '0, rd);
            check_word("serial read data", rd, chain_m[eng]);
            old          = chain_m[eng];
            chain_m[eng] = prev_m;
            prev_m       = old;
            shift_exp[eng] += 32;
            bus_xfer(1'b0, `REG_SER_PREV, '0, '0, rd);
            check_word("non-shifting read", rd, expect_read(`REG_SER_PREV));
            check_chains();
        end

        // Out-of-range select, zeros shift in and no chain moves
        sel   = 8'($urandom_range(8, 255));
        sel_m = sel;
        bus_xfer(1'b1, `REG_SER_SEL, {24'h0, sel}, 4'hF, rd);
        bus_xfer(1'b0, `REG_SER_RD, '0, '0, rd);
        check_word("serial read, no engine", rd, 32'h0);
        prev_m = '0;
        bus_xfer(1'b0, `REG_SER_PREV, '0, '0, rd);
        check_word("non-shifting read, no engine", rd, expect_read(`REG_SER_PREV));
        check_chains();

        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mbist_scan_model.sv ====
// --------------------
// Scan chain model: eight 32-bit chains,
// one behind each engine's serial port
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_scan_model (
    input  logic                      mclk,
    input  logic                      reset_n,
    input  logic [`MBIST_NUM_MEM-1:0] bist_shift,
    input  logic [`MBIST_NUM_MEM-1:0] bist_sdi,
    output logic [`MBIST_NUM_MEM-1:0] bist_sdo
);

    logic [`MBIST_DATA_W-1:0] chain [`MBIST_NUM_MEM];
    // Shift edges seen per engine
    int unsigned              shift_cnt [`MBIST_NUM_MEM];

    // Chain bit 0 faces the engine's sdo
    always_comb begin
        for (int i = 0; i < `MBIST_NUM_MEM; i++) begin
            bist_sdo[i] = reset_n && chain[i][0];
        end
    end

    // sdi enters at the far end, one bit per shift
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `MBIST_NUM_MEM; i++) begin
                // Fill depends on the whole chain index
                chain[i]     <= 32'h5A3C_96E1 ^ (32'(i + 1) * 32'h0101_0101);
                shift_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < `MBIST_NUM_MEM; i++) begin
                if (bist_shift[i]) begin
                    chain[i]     <= {bist_sdi[i], chain[i][`MBIST_DATA_W-1:1]};
                    shift_cnt[i] <= shift_cnt[i] + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mbist_cfg_top.sv ====
// --------------------
// MBIST config block top: decode, register,
// serial shift and read result stages
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_cfg_top (
    input  logic                             mclk,
    input  logic                             reset_n,
    // Register bus
    input  logic                             reg_cs,
    input  logic                             reg_wr,
    input  logic [`MBIST_ADDR_W-1:0]         reg_addr,
    input  logic [`MBIST_DATA_W-1:0]         reg_wdata,
    input  logic [`MBIST_BE_W-1:0]           reg_be,
    output logic [`MBIST_DATA_W-1:0]         reg_rdata,
    output logic                             reg_ack,
    // Engine control levels
    output logic [`MBIST_NUM_MEM-1:0]        bist_en,
    output logic [`MBIST_NUM_MEM-1:0]        bist_run,
    output logic [`MBIST_NUM_MEM-1:0]        bist_load,
    // Engine serial port
    output logic [`MBIST_NUM_MEM-1:0]        bist_sdi,
    output logic [`MBIST_NUM_MEM-1:0]        bist_shift,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_sdo,
    // Engine status
    input  logic [`MBIST_NUM_MEM-1:0]        bist_done,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_error,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_correct,
    input  mbist_cfg_pkg::err_cnt_t          bist_error_cnt
);

    logic [`MBIST_IDX_W-1:0]      reg_idx;
    logic [(1<<`MBIST_IDX_W)-1:0] wr_stb;
    logic                         ser_wr_start;
    logic                         ser_rd_start;
    logic                         ser_acc;
    logic                         plain_acc;
    logic [`MBIST_DATA_W-1:0]     scratch0;
    logic [`MBIST_DATA_W-1:0]     scratch1;
    logic [7:0]                   ser_sel;
    mbist_cfg_pkg::bist_ctrl_u    ctrl_word;
    logic [`MBIST_DATA_W-1:0]     ser_data;
    logic                         ser_done;

    // Decode stage
    mbist_reg_decode u_decode (
        .mclk         (mclk),
        .reset_n      (reset_n),
        .reg_cs       (reg_cs),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_ack      (reg_ack),
        .reg_idx      (reg_idx),
        .wr_stb       (wr_stb),
        .ser_wr_start (ser_wr_start),
        .ser_rd_start (ser_rd_start),
        .ser_acc      (ser_acc),
        .plain_acc    (plain_acc)
    );

    // Execute: config registers
    mbist_ctrl_regs u_regs (
        .mclk      (mclk),
        .reset_n   (reset_n),
        .wr_stb    (wr_stb),
        .reg_wdata (reg_wdata),
        .reg_be    (reg_be),
        .scratch0  (scratch0),
        .scratch1  (scratch1),
        .ser_sel   (ser_sel),
        .ctrl_word (ctrl_word),
        .bist_en   (bist_en),
        .bist_run  (bist_run),
        .bist_load (bist_load)
    );

    // Execute: serial port
    mbist_serial_shift u_shift (
        .mclk         (mclk),
        .reset_n      (reset_n),
        .ser_wr_start (ser_wr_start),
        .ser_rd_start (ser_rd_start),
        .reg_wdata    (reg_wdata),
        .ser_sel      (ser_sel),
        .bist_sdo     (bist_sdo),
        .bist_sdi     (bist_sdi),
        .bist_shift   (bist_shift),
        .ser_data     (ser_data),
        .ser_done     (ser_done)
    );

    // Result stage
    mbist_read_result u_result (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .reg_idx        (reg_idx),
        .ser_acc        (ser_acc),
        .plain_acc      (plain_acc),
        .ser_done       (ser_done),
        .scratch0       (scratch0),
        .scratch1       (scratch1),
        .ser_sel        (ser_sel),
        .ctrl_word      (ctrl_word),
        .ser_data       (ser_data),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack)
    );

endmodule

`default_nettype wire

// ==== verilog/mbist_read_result.sv ====
// --------------------
// Status packing, read mux,
// registered read data and ack
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_read_result (
    input  logic                             mclk,
    input  logic                             reset_n,
    input  logic [`MBIST_IDX_W-1:0]          reg_idx,
    input  logic                             ser_acc,
    input  logic                             plain_acc,
    input  logic                             ser_done,
    input  logic [`MBIST_DATA_W-1:0]         scratch0,
    input  logic [`MBIST_DATA_W-1:0]         scratch1,
    input  logic [7:0]                       ser_sel,
    input  mbist_cfg_pkg::bist_ctrl_u        ctrl_word,
    input  logic [`MBIST_DATA_W-1:0]         ser_data,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_done,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_error,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_correct,
    input  mbist_cfg_pkg::err_cnt_t          bist_error_cnt,
    output logic [`MBIST_DATA_W-1:0]         reg_rdata,
    output logic                             reg_ack
);

    logic [`MBIST_NUM_MEM-1:0][7:0] stat_byte;
    logic [`MBIST_DATA_W-1:0]       rd_mux;
    logic                           ack_set;

    // Per engine: {err_cnt, 0, correct, error, done}
    always_comb begin
        for (int i = 0; i < `MBIST_NUM_MEM; i++) begin
            stat_byte[i] = {bist_error_cnt[i], 1'b0, bist_correct[i],
                            bist_error[i], bist_done[i]};
        end
    end

    // Read mux, unused indices read zero
    always_comb begin
        case (reg_idx)
            `REG_SCRATCH0:  rd_mux = scratch0;
            `REG_SCRATCH1:  rd_mux = scratch1;
            `REG_SER_SEL:   rd_mux = {24'h0, ser_sel};
            `REG_BIST_CTRL: rd_mux = ctrl_word.raw;
            `REG_STATUS_LO: rd_mux = stat_byte[3:0];
            `REG_STATUS_HI: rd_mux = stat_byte[7:4];
            `REG_SER_PREV:  rd_mux = ser_data;
            default:        rd_mux = '0;
        endcase
    end

    // --------------------
    // Ack and read data
    // --------------------
    // Serial acks on shift done, plain on the first cycle of cs
    assign ack_set = (ser_acc && ser_done) || (plain_acc && !reg_ack);

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= ack_set;
        end
    end

    always_ff @(posedge mclk) begin
        if (ack_set) begin
            reg_rdata <= ser_acc ? ser_data : rd_mux;
        end
    end

    // Master drops cs after ack, so ack is always a single pulse
    a_ack_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
        reg_ack |=> !reg_ack);

endmodule

`default_nettype wire

// ==== verilog/mbist_serial_shift.sv ====
// --------------------
// 32-bit serial shifter and counter
// Per-engine routing of shift, sdi and sdo
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_serial_shift (
    input  logic                             mclk,
    input  logic                             reset_n,
    input  logic                             ser_wr_start,
    input  logic                             ser_rd_start,
    input  logic [`MBIST_DATA_W-1:0]         reg_wdata,
    input  logic [7:0]                       ser_sel,
    input  logic [`MBIST_NUM_MEM-1:0]        bist_sdo,
    output logic [`MBIST_NUM_MEM-1:0]        bist_sdi,
    output logic [`MBIST_NUM_MEM-1:0]        bist_shift,
    output logic [`MBIST_DATA_W-1:0]         ser_data,
    output logic                             ser_done
);

    localparam int cnt_w = $clog2(`MBIST_SHIFT_LEN);
    localparam int sel_w = $clog2(`MBIST_NUM_MEM);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`MBIST_SHIFT_LEN - 1);

    logic [`MBIST_DATA_W-1:0]  shifter;
    logic [cnt_w-1:0]          cnt;
    logic                      busy;
    logic                      sel_ok;
    logic                      sdo_sel;
    logic [`MBIST_NUM_MEM-1:0] sel_onehot;

    // Out-of-range select reaches nothing, sdo reads zero
    assign sel_ok  = (ser_sel < 8'(`MBIST_NUM_MEM));
    assign sdo_sel = sel_ok ? bist_sdo[ser_sel[sel_w-1:0]] : 1'b0;

    // Only the selected engine sees shift and sdi
    assign sel_onehot = (busy && sel_ok) ?
                        (`MBIST_NUM_MEM'(1) << ser_sel[sel_w-1:0]) : '0;
    assign bist_shift = sel_onehot;
    assign bist_sdi   = sel_onehot & {`MBIST_NUM_MEM{shifter[0]}};

    assign ser_data = shifter;

    // --------------------
    // Shift sequence
    // --------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            shifter  <= '0;
            cnt      <= '0;
            busy     <= 1'b0;
            ser_done <= 1'b0;
        end else begin
            ser_done <= 1'b0;
            if (ser_wr_start || ser_rd_start) begin
                // Write loads the data first, read shifts what is there
                if (ser_wr_start) begin
                    shifter <= reg_wdata;
                end
                cnt  <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                // LSB out to sdi, engine sdo in at MSB
                shifter <= {sdo_sel, shifter[`MBIST_DATA_W-1:1]};
                cnt     <= cnt + 1'b1;
                if (cnt == cnt_last) begin
                    busy     <= 1'b0;
                    ser_done <= 1'b1;
                end
            end
        end
    end

    // Decode must not issue a new start mid-shift
    a_no_start_busy: assert property (@(posedge mclk) disable iff (!reset_n)
        (ser_wr_start || ser_rd_start) |-> !busy);

    a_shift_onehot: assert property (@(posedge mclk) disable iff (!reset_n)
        $onehot0(bist_shift));

endmodule

`default_nettype wire

// ==== verilog/mbist_ctrl_regs.sv ====
// --------------------
// Scratch, serial select and BIST control registers
// Control word fan-out to engine levels
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_ctrl_regs (
    input  logic                             mclk,
    input  logic                             reset_n,
    input  logic [(1<<`MBIST_IDX_W)-1:0]     wr_stb,
    input  logic [`MBIST_DATA_W-1:0]         reg_wdata,
    input  logic [`MBIST_BE_W-1:0]           reg_be,
    output logic [`MBIST_DATA_W-1:0]         scratch0,
    output logic [`MBIST_DATA_W-1:0]         scratch1,
    output logic [7:0]                       ser_sel,
    output mbist_cfg_pkg::bist_ctrl_u        ctrl_word,
    output logic [`MBIST_NUM_MEM-1:0]        bist_en,
    output logic [`MBIST_NUM_MEM-1:0]        bist_run,
    output logic [`MBIST_NUM_MEM-1:0]        bist_load
);

    // Byte lane merge of write data into current value
    function automatic logic [`MBIST_DATA_W-1:0] be_merge(
        input logic [`MBIST_DATA_W-1:0] cur,
        input logic [`MBIST_DATA_W-1:0] wdata,
        input logic [`MBIST_BE_W-1:0]   be
    );
        logic [`MBIST_DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < `MBIST_BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // --------------------
    // Register writes
    // --------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            scratch0      <= `RST_SCRATCH0;
            scratch1      <= `RST_SCRATCH1;
            ser_sel       <= '0;
            ctrl_word.raw <= '0;
        end else begin
            if (wr_stb[`REG_SCRATCH0]) begin
                scratch0 <= be_merge(scratch0, reg_wdata, reg_be);
            end
            if (wr_stb[`REG_SCRATCH1]) begin
                scratch1 <= be_merge(scratch1, reg_wdata, reg_be);
            end
            // Select lives in byte 0 only
            if (wr_stb[`REG_SER_SEL] && reg_be[0]) begin
                ser_sel <= reg_wdata[7:0];
            end
            if (wr_stb[`REG_BIST_CTRL]) begin
                ctrl_word.raw <= be_merge(ctrl_word.raw, reg_wdata, reg_be);
            end
        end
    end

    // Lane view of control word to per-engine levels
    always_comb begin
        for (int i = 0; i < `MBIST_NUM_MEM; i++) begin
            bist_en[i]   = ctrl_word.lane[i].en;
            bist_run[i]  = ctrl_word.lane[i].run;
            bist_load[i] = ctrl_word.lane[i].load;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mbist_reg_decode.sv ====
// --------------------
// Register bus decode: index, write strobes,
// serial/plain classification, request edge detect
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "mbist_cfg_params.svh"

module mbist_reg_decode (
    input  logic                             mclk,
    input  logic                             reset_n,
    input  logic                             reg_cs,
    input  logic                             reg_wr,
    input  logic [`MBIST_ADDR_W-1:0]         reg_addr,
    input  logic                             reg_ack,
    output logic [`MBIST_IDX_W-1:0]          reg_idx,
    output logic [(1<<`MBIST_IDX_W)-1:0]     wr_stb,
    output logic                             ser_wr_start,
    output logic                             ser_rd_start,
    output logic                             ser_acc,
    output logic                             plain_acc
);

    logic ser_hit;
    logic req;
    logic req_d;
    logic req_rise;

    // Word index from byte address
    assign reg_idx = reg_addr[5:2];

    // One-hot write strobe, held for the whole cycle of cs
    always_comb begin
        wr_stb          = '0;
        wr_stb[reg_idx] = reg_cs && reg_wr;
    end

    // Serial port: write to SER_WR or read from SER_RD
    assign ser_hit = (reg_wr && (reg_idx == `REG_SER_WR)) ||
                     (!reg_wr && (reg_idx == `REG_SER_RD));
    assign ser_acc   = reg_cs && ser_hit;
    assign plain_acc = reg_cs && !ser_hit;

    // --------------------
    // Request edge detect
    // --------------------
    // Request drops once ack returns, so a held cs cannot retrigger
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            req   <= 1'b0;
            req_d <= 1'b0;
        end else begin
            req   <= reg_cs && !reg_ack;
            req_d <= req;
        end
    end

    assign req_rise = req && !req_d;

    // Start pulses only on a fresh request
    assign ser_wr_start = req_rise && ser_acc && reg_wr;
    assign ser_rd_start = req_rise && ser_acc && !reg_wr;

    // Write and read starts are mutually exclusive
    a_start_excl: assert property (@(posedge mclk) disable iff (!reset_n)
        !(ser_wr_start && ser_rd_start));

endmodule

`default_nettype wire

// ==== verilog/mbist_cfg_pkg.sv ====
// --------------------
// Shared types: per-engine control lane,
// control word union, error count array
// --------------------

`default_nettype none

`include "mbist_cfg_params.svh"

package mbist_cfg_pkg;

    // One engine's control nibble, top bit unused
    typedef struct packed {
        logic rsvd;
        logic load;
        logic run;
        logic en;
    } bist_lane_s;

    // Control word, seen flat or as eight lanes
    // Lane 0 sits in bits 3:0
    typedef union packed {
        logic [`MBIST_DATA_W-1:0]         raw;
        bist_lane_s [`MBIST_NUM_MEM-1:0]  lane;
    } bist_ctrl_u;

    // Error count per engine, engine 0 at the bottom
    typedef logic [`MBIST_NUM_MEM-1:0][3:0] err_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/mbist_cfg_params.svh ====
// --------------------
// Bus widths, register map indices,
// scratch reset patterns and serial shift length
// --------------------

`ifndef MBIST_CFG_PARAMS_SVH
`define MBIST_CFG_PARAMS_SVH

// Bus and engine sizing
`define MBIST_NUM_MEM    8
`define MBIST_DATA_W     32
`define MBIST_ADDR_W     8
`define MBIST_BE_W       4
// Index comes from byte address bits 5:2
`define MBIST_IDX_W      4
`define MBIST_SHIFT_LEN  32

// Register map
`define REG_SCRATCH0     4'd0
`define REG_SCRATCH1     4'd1
`define REG_SER_SEL      4'd2
`define REG_BIST_CTRL    4'd3
`define REG_STATUS_LO    4'd4
`define REG_STATUS_HI    4'd5
`define REG_SER_WR       4'd6
`define REG_SER_RD       4'd7
`define REG_SER_PREV     4'd8

// Scratch reset patterns
`define RST_SCRATCH0     32'h4433_2211
`define RST_SCRATCH1     32'hDDCC_BBAA

`endif
